// ==== rtl/avr_link_pkg.sv ====
/*
  ADC frame layout for the two-byte SPI transfer from the microcontroller
  Second byte lands in the upper half of the 16-bit frame
*/
`default_nettype none

package avr_link_pkg;

  localparam int sample_w = 10;
  localparam int chan_w   = 4;

  // Raw view, one byte per SPI transfer
  typedef struct packed {
    logic [7:0] second;
    logic [7:0] first;
  } adc_bytes_t;

  // Decoded view of the same 16 bits
  typedef struct packed {
    logic [chan_w-1:0]   channel;
    logic [1:0]          unused;
    logic [sample_w-9:0] sample_hi;
    logic [7:0]          sample_lo;
  } adc_fields_t;

  typedef union packed {
    adc_bytes_t  bytes;
    adc_fields_t fields;
  } adc_frame_u;

endpackage

`default_nettype wire

// ==== rtl/uart_pkg.sv ====
/*
  8N1 UART framing shared by receiver and transmitter
  Idle line equals the stop level
*/
`default_nettype none

package uart_pkg;

  // Payload bits per character
  localparam int data_bits = 8;

  // Line levels
  localparam logic start_level = 1'b0;
  localparam logic stop_level  = 1'b1;

endpackage

`default_nettype wire

// ==== rtl/cclk_detector.sv ====
/*
  Ready goes high once cclk has been sampled high for CLK_RATE/50000 cycles
  CLK_RATE must be at least 100000 so the settling count is two or more
  A single low sample restarts the wait and drops ready
*/
`default_nettype none

module cclk_detector #(
  parameter int CLK_RATE = 50000000
) (
  input  wire  clk,
  input  wire  rst_n,
  input  wire  cclk,
  output logic ready
);

  // 20 us of settling time
  localparam int SETTLE_CYCLES = CLK_RATE / 50000;
  localparam int CNT_W         = $clog2(SETTLE_CYCLES);

  logic [CNT_W-1:0] cnt;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt   <= '0;
      ready <= 1'b0;
    end else if (!cclk) begin
      // Microcontroller not settled, start over
      cnt   <= '0;
      ready <= 1'b0;
    end else if (cnt == CNT_W'(SETTLE_CYCLES - 1)) begin
      // Count holds at terminal value
      ready <= 1'b1;
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/spi_slave.sv ====
/*
  Mode-0 SPI receiver, MSB first, sampled with the system clock
  sck must stay below a quarter of clk for the synchronizers to see each edge
  No reply data, the caller drives MISO
*/
`default_nettype none

module spi_slave (
  input  wire        clk,
  input  wire        rst_n,
  input  wire        sck,
  input  wire        ss,
  input  wire        mosi,
  output logic       done,
  output logic [7:0] dout
);

  // Two-flop synchronizers for the SPI pins
  logic [1:0] sck_sync;
  logic [1:0] ss_sync;
  logic [1:0] mosi_sync;
  // Previous synchronized sck for edge detect
  logic       sck_prev;
  logic [2:0] bit_cnt;
  logic [7:0] shreg;
  logic       sck_rise;

  assign sck_rise = sck_sync[1] & ~sck_prev;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sck_sync  <= 2'b00;
      ss_sync   <= 2'b11;
      mosi_sync <= 2'b00;
      sck_prev  <= 1'b0;
      bit_cnt   <= 3'd0;
      done      <= 1'b0;
    end else begin
      sck_sync  <= {sck_sync[0], sck};
      ss_sync   <= {ss_sync[0], ss};
      mosi_sync <= {mosi_sync[0], mosi};
      sck_prev  <= sck_sync[1];
      done      <= 1'b0;
      if (ss_sync[1]) begin
        // Deselected, drop any partial byte
        bit_cnt <= 3'd0;
      end else if (sck_rise) begin
        bit_cnt <= bit_cnt + 1'b1;
        // Eighth bit completes the byte
        done    <= (bit_cnt == 3'd7);
      end
    end
  end

  // Shift register, valid whenever done is high
  always_ff @(posedge clk) begin
    if (!ss_sync[1] && sck_rise) begin
      shreg <= {shreg[6:0], mosi_sync[1]};
    end
  end

  assign dout = shreg;

endmodule

`default_nettype wire

// ==== rtl/serial_rx.sv ====
/*
  8N1 UART receiver, samples each bit at its middle
  CLK_PER_BIT must be 2 or more
  Characters with a bad stop bit are dropped without any error flag
*/
`default_nettype none

module serial_rx #(
  parameter int CLK_PER_BIT = 50
) (
  input  wire                              clk,
  input  wire                              rst_n,
  input  wire                              rx,
  output logic [uart_pkg::data_bits-1:0]   data,
  output logic                             new_data
);

  localparam int CTR_W = $clog2(CLK_PER_BIT);
  localparam int IDX_W = $clog2(uart_pkg::data_bits);

  localparam logic [1:0] S_IDLE  = 2'd0;
  localparam logic [1:0] S_START = 2'd1;
  localparam logic [1:0] S_DATA  = 2'd2;
  localparam logic [1:0] S_STOP  = 2'd3;

  logic [1:0]       state;
  logic [CTR_W-1:0] ctr;
  logic [IDX_W-1:0] bit_idx;
  logic [1:0]       rx_sync;
  logic             bit_end;
  logic             half_bit;

  assign bit_end  = (ctr == CTR_W'(CLK_PER_BIT - 1));
  assign half_bit = (ctr == CTR_W'(CLK_PER_BIT / 2 - 1));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= S_IDLE;
      ctr      <= '0;
      bit_idx  <= '0;
      rx_sync  <= {2{uart_pkg::stop_level}};
      new_data <= 1'b0;
    end else begin
      rx_sync  <= {rx_sync[0], rx};
      new_data <= 1'b0;
      ctr      <= ctr + 1'b1;
      case (state)
        S_IDLE: begin
          ctr <= '0;
          if (rx_sync[1] == uart_pkg::start_level) begin
            state <= S_START;
          end
        end
        S_START: begin
          // Confirm the start bit at its center, else treat as a glitch
          if (half_bit) begin
            ctr     <= '0;
            bit_idx <= '0;
            state   <= (rx_sync[1] == uart_pkg::start_level) ? S_DATA : S_IDLE;
          end
        end
        S_DATA: begin
          if (bit_end) begin
            ctr     <= '0;
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == IDX_W'(uart_pkg::data_bits - 1)) begin
              state <= S_STOP;
            end
          end
        end
        default: begin
          // Middle of the stop bit
          if (bit_end) begin
            new_data <= (rx_sync[1] == uart_pkg::stop_level);
            state    <= S_IDLE;
          end
        end
      endcase
    end
  end

  // LSB arrives first, shift right
  always_ff @(posedge clk) begin
    if (state == S_DATA && bit_end) begin
      data <= {rx_sync[1], data[uart_pkg::data_bits-1:1]};
    end
  end

endmodule

`default_nettype wire

// ==== rtl/serial_tx.sv ====
/*
  8N1 UART transmitter
  A byte is taken only while idle and block is low, otherwise it is lost
  busy covers the whole frame and any time block is high
*/
`default_nettype none

module serial_tx #(
  parameter int CLK_PER_BIT = 50
) (
  input  wire                            clk,
  input  wire                            rst_n,
  input  wire [uart_pkg::data_bits-1:0]  data,
  input  wire                            new_data,
  input  wire                            block,
  output logic                           tx,
  output logic                           busy
);

  localparam int CTR_W = $clog2(CLK_PER_BIT);
  localparam int IDX_W = $clog2(uart_pkg::data_bits);

  localparam logic [1:0] S_IDLE  = 2'd0;
  localparam logic [1:0] S_START = 2'd1;
  localparam logic [1:0] S_DATA  = 2'd2;
  localparam logic [1:0] S_STOP  = 2'd3;

  logic [1:0]                    state;
  logic [CTR_W-1:0]              ctr;
  logic [IDX_W-1:0]              bit_idx;
  logic [uart_pkg::data_bits-1:0] shreg;
  logic                          bit_end;
  logic                          accept;

  assign bit_end = (ctr == CTR_W'(CLK_PER_BIT - 1));
  assign accept  = (state == S_IDLE) && new_data && !block;
  assign busy    = (state != S_IDLE) || block;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= S_IDLE;
      ctr     <= '0;
      bit_idx <= '0;
      tx      <= uart_pkg::stop_level;
    end else begin
      ctr <= bit_end ? '0 : ctr + 1'b1;
      case (state)
        S_IDLE: begin
          ctr <= '0;
          tx  <= uart_pkg::stop_level;
          if (accept) begin
            // Start bit goes out on the next cycle
            tx      <= uart_pkg::start_level;
            bit_idx <= '0;
            state   <= S_START;
          end
        end
        S_START: begin
          if (bit_end) begin
            tx    <= shreg[0];
            state <= S_DATA;
          end
        end
        S_DATA: begin
          if (bit_end) begin
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == IDX_W'(uart_pkg::data_bits - 1)) begin
              tx    <= uart_pkg::stop_level;
              state <= S_STOP;
            end else begin
              tx <= shreg[0];
            end
          end
        end
        default: begin
          if (bit_end) begin
            state <= S_IDLE;
          end
        end
      endcase
    end
  end

  // Next bit to send always sits in shreg[0]
  always_ff @(posedge clk) begin
    if (accept) begin
      shreg <= data;
    end else if (bit_end && (state == S_START || state == S_DATA)) begin
      shreg <= shreg >> 1;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/avr_interface.sv ====
/*
  Link to the companion microcontroller over SPI, UART and cclk
  Shared lines come with enables, the pad ring builds the tristate buffers
  Everything except the cclk detector is held in reset until ready
*/
`default_nettype none

module avr_interface #(
  parameter int CLK_RATE         = 50000000,
  parameter int SERIAL_BAUD_RATE = 500000
) (
  input  wire                               clk,
  input  wire                               rst_n,
  input  wire                               cclk,
  input  wire                               spi_sck,
  input  wire                               spi_ss,
  input  wire                               spi_mosi,
  input  wire                               rx,
  input  wire [avr_link_pkg::chan_w-1:0]    channel,
  input  wire [7:0]                         tx_data,
  input  wire                               new_tx_data,
  input  wire                               tx_block,
  output logic                              spi_miso,
  output logic                              spi_miso_oe,
  output logic [avr_link_pkg::chan_w-1:0]   spi_ch,
  output logic                              spi_ch_oe,
  output logic                              tx,
  output logic                              tx_oe,
  output logic                              ready_out,
  output logic                              new_sample,
  output logic [avr_link_pkg::sample_w-1:0] sample,
  output logic [avr_link_pkg::chan_w-1:0]   sample_channel,
  output logic                              tx_busy,
  output logic [7:0]                        rx_data,
  output logic                              new_rx_data
);

  // Bit time rounded up
  localparam int CLK_PER_BIT = (CLK_RATE + SERIAL_BAUD_RATE - 1) / SERIAL_BAUD_RATE;

  logic                     ready;
  logic                     sub_rst_n;
  logic                     spi_done;
  logic [7:0]               spi_dout;
  logic                     byte_cnt;
  avr_link_pkg::adc_frame_u frame;
  // tx_block synchronizer and compare stage
  logic [1:0]               blk_sync;
  logic                     blk_prev;
  logic                     ack_pending;

  cclk_detector #(
    .CLK_RATE(CLK_RATE)
  ) u_cclk_detector (
    .clk  (clk),
    .rst_n(rst_n),
    .cclk (cclk),
    .ready(ready)
  );

  // Reset while the system reset is active or the link is not ready
  assign sub_rst_n = rst_n & ready;

  spi_slave u_spi_slave (
    .clk  (clk),
    .rst_n(sub_rst_n),
    .sck  (spi_sck),
    .ss   (spi_ss),
    .mosi (spi_mosi),
    .done (spi_done),
    .dout (spi_dout)
  );

  serial_rx #(
    .CLK_PER_BIT(CLK_PER_BIT)
  ) u_serial_rx (
    .clk     (clk),
    .rst_n   (sub_rst_n),
    .rx      (rx),
    .data    (rx_data),
    .new_data(new_rx_data)
  );

  // Serial_tx stays blocked until the microcontroller acknowledges the byte
  serial_tx #(
    .CLK_PER_BIT(CLK_PER_BIT)
  ) u_serial_tx (
    .clk     (clk),
    .rst_n   (sub_rst_n),
    .data    (tx_data),
    .new_data(new_tx_data),
    .block   (ack_pending),
    .tx      (tx),
    .busy    (tx_busy)
  );

  always_ff @(posedge clk or negedge sub_rst_n) begin
    if (!sub_rst_n) begin
      byte_cnt    <= 1'b0;
      new_sample  <= 1'b0;
      blk_sync    <= 2'b00;
      blk_prev    <= 1'b0;
      ack_pending <= 1'b0;
    end else begin
      new_sample <= 1'b0;
      // Done wins over a deselect in the same cycle
      if (spi_done) begin
        byte_cnt   <= ~byte_cnt;
        new_sample <= byte_cnt;
      end else if (spi_ss) begin
        byte_cnt <= 1'b0;
      end
      blk_sync <= {blk_sync[0], tx_block};
      blk_prev <= blk_sync[1];
      // Any toggle of tx_block is one acknowledge
      if (blk_sync[1] ^ blk_prev) begin
        ack_pending <= 1'b0;
      end
      if (new_tx_data && !tx_busy) begin
        ack_pending <= 1'b1;
      end
    end
  end

  // Frame bytes written through the raw view
  always_ff @(posedge clk) begin
    if (spi_done) begin
      if (byte_cnt) begin
        frame.bytes.second <= spi_dout;
      end else begin
        frame.bytes.first <= spi_dout;
      end
    end
  end

  // Read back through the field view
  assign sample         = {frame.fields.sample_hi, frame.fields.sample_lo};
  assign sample_channel = frame.fields.channel;

  // MISO carries no data, held high while driven
  assign spi_miso    = 1'b1;
  assign spi_miso_oe = ready & ~spi_ss;
  assign spi_ch      = channel;
  assign spi_ch_oe   = ready;
  assign tx_oe       = ready;
  assign ready_out   = ready;

endmodule

`default_nettype wire

// ==== bench/clock_gen.sv ====
/*
  Free-running testbench clock, period 8 time units
  Starts low at time zero
*/
`default_nettype none

module clock_gen (
  output logic clk
);

  localparam int HALF_PERIOD = 4;

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

endmodule

`default_nettype wire

// ==== bench/avr_interface_assert.sv ====
/*
  Concurrent checks on avr_interface strobes, output enables and the idle tx line
  Each counter holds the number of failures of one assertion
*/
`default_nettype none

module avr_interface_assert (
  input wire clk,
  input wire rst_n,
  input wire ready_out,
  input wire spi_miso_oe,
  input wire spi_ch_oe,
  input wire tx_oe,
  input wire new_sample,
  input wire new_rx_data,
  input wire tx,
  input wire tx_busy
);

  int strobe_fails = 0;
  int enable_fails = 0;
  int idle_fails   = 0;

  // Strobes last exactly one cycle
  a_single_strobe: assert property (@(posedge clk) disable iff (!rst_n)
    (new_sample || new_rx_data) |=> !((new_sample && $past(new_sample)) ||
                                      (new_rx_data && $past(new_rx_data))))
    else begin
      $error("new_sample or new_rx_data high on two consecutive cycles");
      strobe_fails++;
    end

  // Shared lines stay undriven until the link is ready
  a_enables_need_ready: assert property (@(posedge clk) disable iff (!rst_n)
    !ready_out |-> !(spi_miso_oe || spi_ch_oe || tx_oe))
    else begin
      $error("output enable high while ready_out is low");
      enable_fails++;
    end

  // Line rests at the stop level between frames
  a_tx_idle_level: assert property (@(posedge clk) disable iff (!rst_n)
    !tx_busy |-> (tx == uart_pkg::stop_level))
    else begin
      $error("tx away from the stop level while tx_busy is low");
      idle_fails++;
    end

endmodule

`default_nettype wire

// ==== bench/tb_avr_interface.sv ====
/*
  Testbench for avr_interface, operations come from bench/avr_patterns.txt
  Run from the project root so the pattern path resolves
  Bit timings assume CLK_RATE 800000 and SERIAL_BAUD_RATE 100000
*/
`default_nettype none

module tb_avr_interface;

  localparam int CLK_PER_BIT = 8;
  localparam int SCK_HALF    = 4;

  logic       clk;
  logic       rst_n;
  logic       cclk;
  logic       spi_sck;
  logic       spi_ss;
  logic       spi_mosi;
  logic       rx;
  logic [3:0] channel;
  logic [7:0] tx_data;
  logic       new_tx_data;
  logic       tx_block;
  logic       spi_miso;
  logic       spi_miso_oe;
  logic [3:0] spi_ch;
  logic       spi_ch_oe;
  logic       tx;
  logic       tx_oe;
  logic       ready_out;
  logic       new_sample;
  logic [9:0] sample;
  logic [3:0] sample_channel;
  logic       tx_busy;
  logic [7:0] rx_data;
  logic       new_rx_data;

  int checks;
  int errors;
  int timeouts;
  int high_cycles;
  // Strobed results, captured on the clock edge
  logic [9:0] sample_q[$];
  logic [3:0] chan_q[$];
  logic [7:0] rx_q[$];

  clock_gen u_clock_gen (.clk(clk));

  avr_interface #(
    .CLK_RATE        (800000),
    .SERIAL_BAUD_RATE(100000)
  ) u_avr_interface (
    .clk(clk), .rst_n(rst_n), .cclk(cclk),
    .spi_sck(spi_sck), .spi_ss(spi_ss), .spi_mosi(spi_mosi), .rx(rx),
    .channel(channel), .tx_data(tx_data), .new_tx_data(new_tx_data), .tx_block(tx_block),
    .spi_miso(spi_miso), .spi_miso_oe(spi_miso_oe), .spi_ch(spi_ch), .spi_ch_oe(spi_ch_oe),
    .tx(tx), .tx_oe(tx_oe), .ready_out(ready_out), .new_sample(new_sample),
    .sample(sample), .sample_channel(sample_channel), .tx_busy(tx_busy),
    .rx_data(rx_data), .new_rx_data(new_rx_data)
  );

  bind avr_interface avr_interface_assert u_avr_interface_assert (
    .clk(clk), .rst_n(rst_n), .ready_out(ready_out), .spi_miso_oe(spi_miso_oe),
    .spi_ch_oe(spi_ch_oe), .tx_oe(tx_oe), .new_sample(new_sample),
    .new_rx_data(new_rx_data), .tx(tx), .tx_busy(tx_busy)
  );

  always @(posedge clk) begin
    if (new_sample === 1'b1) begin
      sample_q.push_back(sample);
      chan_q.push_back(sample_channel);
    end
    if (new_rx_data === 1'b1) begin
      rx_q.push_back(rx_data);
    end
  end

  task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at time %0t: %s, got %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  // Polls one capture queue at the falling edge until it holds an entry
  task automatic wait_strobe(input bit on_rx, input int limit, output bit ok);
    int waited;
    waited = 0;
    while ((on_rx ? rx_q.size() : sample_q.size()) == 0 && waited < limit) begin
      @(negedge clk);
      waited++;
    end
    ok = (on_rx ? rx_q.size() : sample_q.size()) != 0;
    if (!ok) begin
      timeouts++;
      $display("Timed out after %0d cycles waiting for %s", limit,
               on_rx ? "new_rx_data" : "new_sample");
    end
  endtask

  // Everything stays quiet while cclk has not settled
  task automatic hold_cclk(input logic lvl, input int n);
    @(posedge clk);
    cclk <= lvl;
    repeat (n) begin
      @(posedge clk);
      @(negedge clk);
      check(32'(ready_out), 0, "ready_out before settling");
      check(32'({spi_miso_oe, spi_ch_oe, tx_oe}), 0, "enables before ready");
      check(32'({new_sample, new_rx_data, tx_busy}), 0, "strobes before ready");
    end
    high_cycles = lvl ? n : 0;
  endtask

  task automatic wait_ready(input logic [31:0] settle);
    int waited;
    waited = 0;
    while (ready_out !== 1'b1 && waited < 64) begin
      @(negedge clk);
      waited++;
    end
    if (ready_out !== 1'b1) begin
      timeouts++;
      $display("Timed out after 64 cycles waiting for ready_out");
      return;
    end
    check(32'(high_cycles + waited), settle, "cclk high cycles before ready");
    check(32'({spi_ch_oe, tx_oe, spi_miso_oe}), 32'h6, "enables once ready");
    check(32'(spi_ch), 32'(channel), "spi_ch follows channel");
  endtask

  // Mode 0, MSB first, mosi changes while sck is low
  task automatic spi_byte(input logic [7:0] b);
    int i;
    for (i = 7; i >= 0; i--) begin
      @(posedge clk);
      spi_mosi <= b[i];
      spi_sck  <= 1'b0;
      repeat (SCK_HALF - 1) @(posedge clk);
      @(posedge clk);
      spi_sck <= 1'b1;
      repeat (SCK_HALF - 1) @(posedge clk);
    end
    @(posedge clk);
    spi_sck <= 1'b0;
    repeat (SCK_HALF - 1) @(posedge clk);
  endtask

  task automatic run_frame(input logic [7:0] b1, input logic [7:0] b2,
                           input logic [31:0] exp_sample, input logic [31:0] exp_chan,
                           input bit full);
    bit ok;
    @(posedge clk);
    spi_ss <= 1'b0;
    @(negedge clk);
    check(32'({spi_miso_oe, spi_miso}), 32'h3, "MISO enable and level while selected");
    spi_byte(b1);
    if (full) begin
      spi_byte(b2);
    end
    @(posedge clk);
    spi_ss <= 1'b1;
    @(negedge clk);
    check(32'(spi_miso_oe), 0, "MISO enable after deselect");
    if (full) begin
      wait_strobe(1'b0, 32, ok);
      if (!ok) begin
        return;
      end
    end
    repeat (16) @(negedge clk);
    if (full) begin
      check(32'(sample_q.size()), 1, "new_sample count per frame");
      if (sample_q.size() != 0) begin
        check(32'(sample_q.pop_front()), exp_sample, "sample");
        check(32'(chan_q.pop_front()), exp_chan, "sample_channel");
      end
    end else begin
      check(32'(sample_q.size()), 0, "new_sample count after aborted frame");
    end
    sample_q.delete();
    chan_q.delete();
  endtask

  task automatic send_uart(input logic [7:0] b, input logic stop);
    logic [9:0] bits;
    int i;
    bit ok;
    bits = {stop, b, uart_pkg::start_level};
    for (i = 0; i < 10; i++) begin
      @(posedge clk);
      rx <= bits[i];
      repeat (CLK_PER_BIT - 1) @(posedge clk);
    end
    @(posedge clk);
    rx <= uart_pkg::stop_level;
    if (stop == uart_pkg::stop_level) begin
      wait_strobe(1'b1, 32, ok);
      if (!ok) begin
        return;
      end
      repeat (3 * CLK_PER_BIT) @(negedge clk);
      check(32'(rx_q.size()), 1, "new_rx_data count per byte");
      if (rx_q.size() != 0) begin
        check(32'(rx_q.pop_front()), 32'(b), "rx_data");
      end
    end else begin
      repeat (3 * CLK_PER_BIT) @(negedge clk);
      check(32'(rx_q.size()), 0, "new_rx_data count after bad stop bit");
    end
    rx_q.delete();
  endtask

  // Samples tx at mid-bit, then checks the acknowledge gate
  task automatic run_tx(input logic [7:0] b, input logic [7:0] extra);
    logic [7:0] got;
    int i;
    int waited;
    check(32'(tx_busy), 0, "tx_busy before a send");
    @(posedge clk);
    tx_data     <= b;
    new_tx_data <= 1'b1;
    @(posedge clk);
    new_tx_data <= 1'b0;
    waited = 0;
    do begin
      @(negedge clk);
      waited++;
    end while (tx !== uart_pkg::start_level && waited < 4 * CLK_PER_BIT);
    if (tx !== uart_pkg::start_level) begin
      timeouts++;
      $display("Timed out waiting for the tx start bit");
      return;
    end
    repeat (CLK_PER_BIT / 2) @(negedge clk);
    check(32'(tx), 32'(uart_pkg::start_level), "tx start bit");
    for (i = 0; i < 8; i++) begin
      repeat (CLK_PER_BIT) @(negedge clk);
      got[i] = tx;
    end
    repeat (CLK_PER_BIT) @(negedge clk);
    check(32'(tx), 32'(uart_pkg::stop_level), "tx stop bit");
    check(32'(got), 32'(b), "tx data bits");
    repeat (CLK_PER_BIT) @(negedge clk);
    check(32'(tx_busy), 1, "tx_busy held until acknowledge");
    // Strobe while blocked must be dropped
    @(posedge clk);
    tx_data     <= extra;
    new_tx_data <= 1'b1;
    @(posedge clk);
    new_tx_data <= 1'b0;
    repeat (2 * CLK_PER_BIT) begin
      @(negedge clk);
      check(32'({tx_busy, tx}), 32'({1'b1, uart_pkg::stop_level}), "tx while awaiting ack");
    end
    @(posedge clk);
    tx_block <= ~tx_block;
    waited = 0;
    do begin
      @(negedge clk);
      waited++;
    end while (tx_busy !== 1'b0 && waited < 16);
    if (tx_busy !== 1'b0) begin
      timeouts++;
      $display("Timed out waiting for tx_busy to fall after tx_block toggled");
      return;
    end
    repeat (3 * CLK_PER_BIT) begin
      @(negedge clk);
      check(32'({tx_busy, tx}), 32'({1'b0, uart_pkg::stop_level}), "tx idle after ack");
    end
  endtask

  function automatic bit operands_ok(input int got, input int want, input string op);
    if (got != want) begin
      errors++;
      $display("Pattern line for %s has %0d operands instead of %0d", op, got, want);
      return 1'b0;
    end
    return 1'b1;
  endfunction

  initial begin
    int fd;
    int n;
    int assert_fails;
    string op;
    string rest;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    logic [31:0] d;
    checks      = 0;
    errors      = 0;
    timeouts    = 0;
    high_cycles = 0;
    rst_n       <= 1'b0;
    cclk        <= 1'b0;
    spi_sck     <= 1'b0;
    spi_ss      <= 1'b1;
    spi_mosi    <= 1'b0;
    rx          <= uart_pkg::stop_level;
    channel     <= 4'h5;
    tx_data     <= 8'h00;
    new_tx_data <= 1'b0;
    tx_block    <= 1'b0;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;

    fd = $fopen("bench/avr_patterns.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("Could not open the pattern file bench/avr_patterns.txt");
    end else begin
      while (timeouts == 0) begin
        n = $fscanf(fd, "%s", op);
        if (n != 1) begin
          break;
        end
        if (op[0] == 8'h23) begin
          n = $fgets(rest, fd);
        end else if (op == "cclk") begin
          n = $fscanf(fd, "%h %h", a, b);
          if (operands_ok(n, 2, op)) hold_cclk(a[0], int'(b));
        end else if (op == "ready") begin
          n = $fscanf(fd, "%h", a);
          if (operands_ok(n, 1, op)) wait_ready(a);
        end else if (op == "spi") begin
          n = $fscanf(fd, "%h %h %h %h", a, b, c, d);
          if (operands_ok(n, 4, op)) run_frame(a[7:0], b[7:0], c, d, 1'b1);
        end else if (op == "abort") begin
          n = $fscanf(fd, "%h", a);
          if (operands_ok(n, 1, op)) run_frame(a[7:0], 8'h00, 0, 0, 1'b0);
        end else if (op == "rx") begin
          n = $fscanf(fd, "%h %h", a, b);
          if (operands_ok(n, 2, op)) send_uart(a[7:0], b[0]);
        end else if (op == "tx") begin
          n = $fscanf(fd, "%h %h", a, b);
          if (operands_ok(n, 2, op)) run_tx(a[7:0], b[7:0]);
        end else begin
          errors++;
          $display("Unknown operation %s in the pattern file", op);
          n = $fgets(rest, fd);
        end
      end
      $fclose(fd);
    end

    assert_fails = u_avr_interface.u_avr_interface_assert.strobe_fails +
                   u_avr_interface.u_avr_interface_assert.enable_fails +
                   u_avr_interface.u_avr_interface_assert.idle_fails;
    $display("Checks %0d, value errors %0d, timeouts %0d, assertion failures %0d",
             checks, errors, timeouts, assert_fails);
    if (errors == 0 && timeouts == 0 && assert_fails == 0 && checks != 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== bench/avr_patterns.txt ====
# One operation per line, operands in hex
# cclk lvl cycles | ready settle | spi b1 b2 sample chan | abort b1 | rx byte stop | tx byte ignored
cclk 1 a
cclk 0 2
cclk 1 5
cclk 0 1
cclk 1 f
ready 10
spi 5a 97 35a 9
spi ff 03 3ff 0
spi 00 f0 000 f
abort c3
spi 12 6d 112 6
abort 81
spi a5 32 2a5 3
rx a5 1
rx 3c 1
rx 7e 0
rx 81 1
rx 00 0
rx ff 1
tx a5 5a
tx 0f f0
tx 80 01

// ==== filelist.f ====
rtl/avr_link_pkg.sv
rtl/uart_pkg.sv
rtl/cclk_detector.sv
rtl/spi_slave.sv
rtl/serial_rx.sv
rtl/serial_tx.sv
rtl/avr_interface.sv
bench/clock_gen.sv
bench/avr_interface_assert.sv
bench/tb_avr_interface.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_avr_interface
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
RUN_FLAGS ?= +verilator+error+limit+100
PASS_MSG  := Simulation PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(RUN_FLAGS) 2>&1)"; echo "$$out"; \
	  echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
